// File: src/inlier_pkg.sv
`default_nettype none

package inlier_pkg;

    // input values are Q8.8, first-layer results Q16.16 and the compare value Q32.32
    localparam int single_w = 16;
    localparam int single_fbits = 8;
    localparam int double_w = 32;
    localparam int double_fbits = 16;
    localparam int quad_w = 64;

    typedef logic signed [single_w-1:0] single_t;
    typedef logic signed [double_w-1:0] double_t;
    typedef logic signed [quad_w-1:0] quad_t;

    typedef struct packed {
        single_t x;
        single_t y;
        single_t z;
    } vector3_s;

    // first-layer calculations, each one multiply-add on the small unit
    // the z terms come first so the x terms hold the finished sums
    typedef enum logic [2:0] {
        CALC_NULL,
        CALC_TT,
        CALC_NN_Z,
        CALC_NN_Y,
        CALC_NN_X,
        CALC_NP_Z,
        CALC_NP_Y,
        CALC_NP_X
    } calc_e;

    // selects one of the eight captured input values
    typedef enum logic [2:0] {T, D, NX, NY, NZ, PX, PY, PZ} input_e;

    typedef struct packed {
        single_t a;
        single_t b;
        double_t c;
        calc_e   tag;
    } small_req_s;

    // tag 0 marks the square of n.p - d and tag 1 the final compare value
    typedef struct packed {
        double_t a;
        double_t b;
        quad_t   c;
        logic    tag;
    } large_req_s;

    typedef enum logic [2:0] {IDLE, FIRST_LAYER, SQUARE, FINAL, DONE} seq_state_e;

endpackage

`default_nettype wire

// File: src/fixed_fma.sv
`timescale 1ns/1ps
`default_nettype none

// signed multiply-add r = a*b + c with a fixed number of pipeline stages
// a new operation can enter on every cycle and results leave in issue order
module fixed_fma #(
    parameter int width = 16,
    parameter int latency = 3
) (
    input  wire logic                     clock,
    input  wire logic                     rst,
    input  wire logic                     in_valid,
    input  wire logic signed [width-1:0]  a,
    input  wire logic signed [width-1:0]  b,
    input  wire logic signed [2*width-1:0] c,
    input  wire logic [2:0]               in_tag,
    output logic                          out_valid,
    output logic signed [2*width-1:0]     result,
    output logic [2:0]                    out_tag
);

    localparam int rw = 2 * width;

    logic signed [rw-1:0] product_sum;
    logic [latency-1:0]   valid_pipe;
    logic signed [rw-1:0] result_pipe [latency];
    logic [2:0]           tag_pipe [latency];

    // operands are sign extended to the result width, so the sum wraps at 2*width bits
    always_comb begin
        product_sum = a * b + c;
    end

    // the valid bits are the only control state in the pipe
    always_ff @(posedge clock) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= in_valid;
            for (int i = 1; i < latency; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // result and tag march alongside their valid bit
    always_ff @(posedge clock) begin
        result_pipe[0] <= product_sum;
        tag_pipe[0] <= in_tag;
        for (int i = 1; i < latency; i++) begin
            result_pipe[i] <= result_pipe[i-1];
            tag_pipe[i] <= tag_pipe[i-1];
        end
    end

    assign out_valid = valid_pipe[latency-1];
    assign result = result_pipe[latency-1];
    assign out_tag = tag_pipe[latency-1];

endmodule

`default_nettype wire

// File: src/operand_capture.sv
`timescale 1ns/1ps
`default_nettype none

// holds the captured inputs and the constant table of first-layer calculations
// the scheduler names a calculation and gets back its operands and dependency
module operand_capture
    import inlier_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     load,
    input  wire vector3_s n,
    input  wire vector3_s p,
    input  wire single_t  d,
    input  wire single_t  t,
    input  wire calc_e    calc,
    output single_t       a,
    output single_t       b,
    output calc_e         dep,
    output logic          c_is_neg_d,
    output double_t       neg_d
);

    single_t captured [8];
    input_e  sel_a;
    input_e  sel_b;

    // the sequencer raises load on every idle cycle, so the last idle cycle wins
    always_ff @(posedge clock) begin
        if (load) begin
            captured[T] <= t;
            captured[D] <= d;
            captured[NX] <= n.x;
            captured[NY] <= n.y;
            captured[NZ] <= n.z;
            captured[PX] <= p.x;
            captured[PY] <= p.y;
            captured[PZ] <= p.z;
        end
    end

    // each dot product is a chain z then y then x, every step adding the one before
    always_comb begin
        c_is_neg_d = 1'b0;
        case (calc)
            CALC_TT:   begin sel_a = T;  sel_b = T;  dep = CALC_NULL; end
            CALC_NN_Z: begin sel_a = NZ; sel_b = NZ; dep = CALC_NULL; end
            CALC_NN_Y: begin sel_a = NY; sel_b = NY; dep = CALC_NN_Z; end
            CALC_NN_X: begin sel_a = NX; sel_b = NX; dep = CALC_NN_Y; end
            CALC_NP_Y: begin sel_a = NY; sel_b = PY; dep = CALC_NP_Z; end
            CALC_NP_X: begin sel_a = NX; sel_b = PX; dep = CALC_NP_Y; end
            CALC_NP_Z: begin
                sel_a = NZ;
                sel_b = PZ;
                dep = CALC_NULL;
                // the plane offset enters as the seed of the n.p chain
                c_is_neg_d = 1'b1;
            end
            default:   begin sel_a = T;  sel_b = T;  dep = CALC_NULL; end
        endcase
    end

    assign a = captured[sel_a];
    assign b = captured[sel_b];

    // d moves from Q8.8 to Q16.16 before it is negated
    assign neg_d = -(double_t'(captured[D]) <<< (double_fbits - single_fbits));

endmodule

`default_nettype wire

// File: src/first_layer_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

// runs the seven first-layer multiply-adds on the small unit
// a calculation may issue once the calculation it depends on has finished
module first_layer_scheduler
    import inlier_pkg::*;
(
    input  wire logic    clock,
    input  wire logic    rst,
    input  wire logic    start,
    output calc_e        calc,
    input  wire single_t a,
    input  wire single_t b,
    input  wire calc_e   dep,
    input  wire logic    c_is_neg_d,
    input  wire double_t neg_d,
    output logic         small_valid,
    output small_req_s   small_req,
    input  wire logic    small_done,
    input  wire double_t small_result,
    input  wire calc_e   small_tag,
    output logic         first_done,
    output double_t      tt,
    output double_t      nn,
    output double_t      npd
);

    typedef enum logic [1:0] {PENDING, RUNNING, FINISHED} calc_state_e;

    calc_state_e calc_state [1:7];
    double_t     results [1:7];
    calc_e       wait_on [1:7];
    logic [7:1]  blocked;
    logic        busy;

    logic [7:0]  done_vec;
    logic        found;
    logic        dep_ready;
    logic        retire;

    // index 0 stands for CALC_NULL, which counts as finished at all times
    always_comb begin
        done_vec[0] = 1'b1;
        for (int i = 1; i < 8; i++) begin
            done_vec[i] = (calc_state[i] == FINISHED);
        end
    end

    // probe the lowest pending calculation that is not known to be waiting
    // a calculation seen waiting remembers its dependency and is skipped until that finishes
    always_comb begin
        found = 1'b0;
        calc = CALC_NULL;
        for (int i = 7; i >= 1; i--) begin
            if (calc_state[i] == PENDING && (!blocked[i] || done_vec[wait_on[i]])) begin
                found = 1'b1;
                calc = calc_e'(i);
            end
        end
    end

    assign dep_ready = done_vec[dep];
    assign small_valid = busy && found && dep_ready;
    assign retire = small_done && (small_tag != CALC_NULL);

    // the addend is the running sum of the chain, or the seed when the chain starts here
    always_comb begin
        small_req.a = a;
        small_req.b = b;
        small_req.tag = calc;
        if (dep != CALC_NULL) begin
            small_req.c = results[dep];
        end else if (c_is_neg_d) begin
            small_req.c = neg_d;
        end else begin
            small_req.c = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || start) begin
            busy <= start && !rst;
            blocked <= '0;
            for (int i = 1; i < 8; i++) begin
                calc_state[i] <= PENDING;
            end
        end else if (busy) begin
            if (first_done) begin
                busy <= 1'b0;
            end
            if (found && !dep_ready) begin
                blocked[calc] <= 1'b1;
            end
            if (small_valid) begin
                calc_state[calc] <= RUNNING;
            end
            // issue and retire never touch the same calculation in one cycle
            if (retire) begin
                calc_state[small_tag] <= FINISHED;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (found && !dep_ready) begin
            wait_on[calc] <= dep;
        end
        if (retire) begin
            results[small_tag] <= small_result;
        end
    end

    // all seven done while busy lasts exactly one cycle since busy drops with it
    assign first_done = busy && (&done_vec);

    assign tt = results[CALC_TT];
    assign nn = results[CALC_NN_X];
    assign npd = results[CALC_NP_X];

endmodule

`default_nettype wire

// File: src/inlier_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// top-level control of one inlier check
// it accepts inputs while idle, waits for the first layer, runs the two
// large multiply-adds and holds the result until it is acknowledged
module inlier_sequencer
    import inlier_pkg::*;
(
    input  wire logic    clock,
    input  wire logic    rst,
    input  wire logic    ivalid,
    output logic         iready,
    output logic         ovalid,
    input  wire logic    oacknowledge,
    output logic         inlier,
    output logic         load,
    output logic         start,
    input  wire logic    first_done,
    input  wire double_t tt,
    input  wire double_t nn,
    input  wire double_t npd,
    output logic         large_valid,
    output large_req_s   large_req,
    input  wire logic    large_done,
    input  wire quad_t   large_result,
    input  wire logic    large_tag
)
;

    seq_state_e state;
    quad_t      square;
    logic       issue_square;
    logic       issue_final;
    logic       square_back;
    logic       final_back;

    assign iready = (state == IDLE);
    assign ovalid = (state == DONE);

    // inputs are sampled on every idle cycle, including the one that accepts them
    assign load = (state == IDLE);
    assign start = (state == IDLE) && ivalid;

    // the square goes out in the same cycle as first_done, when all sums are final
    assign issue_square = (state == FIRST_LAYER) && first_done;
    assign square_back = (state == SQUARE) && large_done && !large_tag;
    assign final_back = (state == FINAL) && large_done && large_tag;

    assign large_valid = issue_square || issue_final;

    // final step is tt*nn - npd^2, the square before that is npd*npd + 0
    always_comb begin
        large_req.tag = issue_final;
        if (issue_final) begin
            large_req.a = tt;
            large_req.b = nn;
            large_req.c = -square;
        end else begin
            large_req.a = npd;
            large_req.b = npd;
            large_req.c = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= IDLE;
            issue_final <= 1'b0;
        end else begin
            // issue_final is a one-cycle pulse on entry to FINAL
            issue_final <= square_back;
            case (state)
                IDLE: begin
                    if (ivalid) begin
                        state <= FIRST_LAYER;
                    end
                end
                FIRST_LAYER: begin
                    if (first_done) begin
                        state <= SQUARE;
                    end
                end
                SQUARE: begin
                    if (square_back) begin
                        state <= FINAL;
                    end
                end
                FINAL: begin
                    if (final_back) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (oacknowledge) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // the point is an inlier when the compare value is not negative
    always_ff @(posedge clock) begin
        if (square_back) begin
            square <= large_result;
        end
        if (final_back) begin
            inlier <= !large_result[quad_w-1];
        end
    end

endmodule

`default_nettype wire

// File: src/check_inlier.sv
`timescale 1ns/1ps
`default_nettype none

// slab test for a point p against the plane n.p = d with half-width t
// inlier is set when t*t*(n.n) - (n.p - d)^2 is not negative
module check_inlier
    import inlier_pkg::*;
#(
    parameter int small_latency = 3,
    parameter int large_latency = 4
) (
    input  wire logic     clock,
    input  wire logic     rst,
    input  wire logic     ivalid,
    output logic          iready,
    input  wire vector3_s n,
    input  wire vector3_s p,
    input  wire single_t  d,
    input  wire single_t  t,
    output logic          ovalid,
    input  wire logic     oacknowledge,
    output logic          inlier
);

    logic       load;
    logic       start;
    logic       first_done;
    calc_e      calc;
    single_t    op_a;
    single_t    op_b;
    calc_e      dep;
    logic       c_is_neg_d;
    double_t    neg_d;
    logic       small_valid;
    small_req_s small_req;
    logic       small_done;
    double_t    small_result;
    logic [2:0] small_tag_bits;
    double_t    tt;
    double_t    nn;
    double_t    npd;
    logic       large_valid;
    large_req_s large_req;
    logic       large_done;
    quad_t      large_result;
    logic [2:0] large_tag_bits;

    operand_capture u_operand_capture (
        .clock      (clock),
        .load       (load),
        .n          (n),
        .p          (p),
        .d          (d),
        .t          (t),
        .calc       (calc),
        .a          (op_a),
        .b          (op_b),
        .dep        (dep),
        .c_is_neg_d (c_is_neg_d),
        .neg_d      (neg_d)
    );

    first_layer_scheduler u_first_layer_scheduler (
        .clock        (clock),
        .rst          (rst),
        .start        (start),
        .calc         (calc),
        .a            (op_a),
        .b            (op_b),
        .dep          (dep),
        .c_is_neg_d   (c_is_neg_d),
        .neg_d        (neg_d),
        .small_valid  (small_valid),
        .small_req    (small_req),
        .small_done   (small_done),
        .small_result (small_result),
        .small_tag    (calc_e'(small_tag_bits)),
        .first_done   (first_done),
        .tt           (tt),
        .nn           (nn),
        .npd          (npd)
    );

    inlier_sequencer u_inlier_sequencer (
        .clock        (clock),
        .rst          (rst),
        .ivalid       (ivalid),
        .iready       (iready),
        .ovalid       (ovalid),
        .oacknowledge (oacknowledge),
        .inlier       (inlier),
        .load         (load),
        .start        (start),
        .first_done   (first_done),
        .tt           (tt),
        .nn           (nn),
        .npd          (npd),
        .large_valid  (large_valid),
        .large_req    (large_req),
        .large_done   (large_done),
        .large_result (large_result),
        .large_tag    (large_tag_bits[0])
    );

    // Q8.8 by Q8.8 products land in Q16.16
    fixed_fma #(
        .width   (single_w),
        .latency (small_latency)
    ) small_fma (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (small_valid),
        .a         (small_req.a),
        .b         (small_req.b),
        .c         (small_req.c),
        .in_tag    (small_req.tag),
        .out_valid (small_done),
        .result    (small_result),
        .out_tag   (small_tag_bits)
    );

    // Q16.16 by Q16.16 products land in Q32.32, only the low tag bit is in use
    fixed_fma #(
        .width   (double_w),
        .latency (large_latency)
    ) large_fma (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (large_valid),
        .a         (large_req.a),
        .b         (large_req.b),
        .c         (large_req.c),
        .in_tag    ({2'b00, large_req.tag}),
        .out_valid (large_done),
        .result    (large_result),
        .out_tag   (large_tag_bits)
    );

endmodule

`default_nettype wire

// File: test/inlier_checker.sv
`timescale 1ns/1ps
`default_nettype none

// watches the DUT ports, predicts the inlier bit for every accepted input
// and checks the handshake rules on every clock edge
module inlier_checker
    import inlier_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     rst,
    input  wire logic     ivalid,
    input  wire logic     iready,
    input  wire vector3_s n,
    input  wire vector3_s p,
    input  wire single_t  d,
    input  wire single_t  t,
    input  wire logic     ovalid,
    input  wire logic     oacknowledge,
    input  wire logic     inlier,
    output int            error_count,
    output int            accept_count,
    output int            result_count
);

    // one accepted input together with the bit it should produce
    typedef struct packed {
        vector3_s n;
        vector3_s p;
        single_t  d;
        single_t  t;
        logic     inlier;
    } expect_s;

    expect_s expect_q[$];
    expect_s current;
    logic    busy;
    logic    holding;
    logic    held_inlier;

    // t*t*(n.n) - (n.p - d)^2 with Q16.16 first-layer sums and a Q32.32 compare
    function automatic logic slab_reference(vector3_s nv, vector3_s pv, single_t dv, single_t tv);
        double_t tt;
        double_t nn;
        double_t npd;
        quad_t   compare;
        tt = double_t'(tv) * double_t'(tv);
        nn = double_t'(nv.x) * double_t'(nv.x) + double_t'(nv.y) * double_t'(nv.y)
            + double_t'(nv.z) * double_t'(nv.z);
        // d sits in Q8.8, so eight more fraction bits bring it to Q16.16
        npd = double_t'(nv.x) * double_t'(pv.x) + double_t'(nv.y) * double_t'(pv.y)
            + double_t'(nv.z) * double_t'(pv.z) - (double_t'(dv) <<< 8);
        compare = quad_t'(tt) * quad_t'(nn) - quad_t'(npd) * quad_t'(npd);
        return !compare[quad_w-1];
    endfunction

    initial begin
        error_count = 0;
        accept_count = 0;
        result_count = 0;
        busy = 1'b0;
        holding = 1'b0;
        held_inlier = 1'b0;
    end

    // all ports are read as they stood just before the edge
    always @(posedge clock) begin
        if (rst) begin
            busy = 1'b0;
            holding = 1'b0;
            expect_q.delete();
        end else if (!busy) begin
            if (ovalid) begin
                $display("error: ovalid is high while the checker is idle");
                error_count++;
            end
            if (!iready) begin
                $display("error: iready is low while the checker is idle");
                error_count++;
            end
            if (ivalid && iready) begin
                expect_q.push_back({n, p, d, t, slab_reference(n, p, d, t)});
                accept_count++;
                busy = 1'b1;
            end
        end else begin
            if (iready) begin
                $display("error: iready is high while a check is in progress");
                error_count++;
            end
            // a result that is not yet acknowledged must not move
            if (holding && !ovalid) begin
                $display("error: ovalid dropped before the result was acknowledged");
                error_count++;
            end
            if (holding && ovalid && inlier !== held_inlier) begin
                $display("[FAIL] inlier: changed from 0x%h to 0x%h while held",
                    held_inlier, inlier);
                error_count++;
            end
            holding = ovalid && !oacknowledge;
            held_inlier = inlier;
            if (ovalid && oacknowledge) begin
                current = expect_q.pop_front();
                if (inlier !== current.inlier) begin
                    $display("[FAIL] inlier: expected 0x%h, got 0x%h for n=0x%h p=0x%h d=0x%h t=0x%h",
                        current.inlier, inlier, current.n, current.p, current.d, current.t);
                    error_count++;
                end
                result_count++;
                busy = 1'b0;
                holding = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_check_inlier.sv
`timescale 1ns/1ps
`default_nettype none

// drives random and directed slabs into the checker and paces the acknowledge
module tb_check_inlier
    import inlier_pkg::*;
;

    localparam int random_tests = 300;
    localparam int directed_tests = 3;
    // a single check needs well under 80 cycles even with the longest acknowledge delay
    localparam int timeout_cycles = (random_tests + directed_tests) * 80;

    logic       clock;
    logic       rst;
    logic       ivalid;
    logic       iready;
    vector3_s   n;
    vector3_s   p;
    single_t    d;
    single_t    t;
    logic       ovalid;
    logic       oacknowledge;
    logic       inlier;
    int         error_count;
    int         accept_count;
    int         result_count;
    int         tb_errors = 0;
    int         cycle_count = 0;
    logic [31:0] stim_state = 32'ha9e2e1f4;
    logic [31:0] ack_state = 32'ha9e2e1f4;

    check_inlier DUT (
        .clock        (clock),
        .rst          (rst),
        .ivalid       (ivalid),
        .iready       (iready),
        .n            (n),
        .p            (p),
        .d            (d),
        .t            (t),
        .ovalid       (ovalid),
        .oacknowledge (oacknowledge),
        .inlier       (inlier)
    );

    inlier_checker u_checker (
        .clock        (clock),
        .rst          (rst),
        .ivalid       (ivalid),
        .iready       (iready),
        .n            (n),
        .p            (p),
        .d            (d),
        .t            (t),
        .ovalid       (ovalid),
        .oacknowledge (oacknowledge),
        .inlier       (inlier),
        .error_count  (error_count),
        .accept_count (accept_count),
        .result_count (result_count)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // one LFSR step per bit, the newest bit ends up in bit 0
    task automatic draw_bits(inout logic [31:0] state, input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            state = lfsr_step(state);
            value = {value[30:0], state[0]};
        end
    endtask

    // magnitudes below 4.0 keep every product far from the wrap points
    task automatic random_value(output single_t value);
        logic [31:0] bits;
        single_t     magnitude;
        draw_bits(stim_state, 10, bits);
        magnitude = {6'b0, bits[9:0]};
        draw_bits(stim_state, 1, bits);
        value = bits[0] ? -magnitude : magnitude;
    endtask

    task automatic random_vector(output vector3_s value);
        single_t x;
        single_t y;
        single_t z;
        random_value(x);
        random_value(y);
        random_value(z);
        value = {x, y, z};
    endtask

    // offers one input while idle and returns the inlier bit seen at the acknowledge
    task automatic apply_input(input vector3_s nv, input vector3_s pv, input single_t dv,
                               input single_t tv, input logic noisy, output logic result);
        logic [31:0] bits;
        vector3_s    junk_n;
        vector3_s    junk_p;
        single_t     junk_d;
        @(posedge clock);
        while (!iready) begin
            @(posedge clock);
        end
        n <= nv;
        p <= pv;
        d <= dv;
        t <= tv;
        ivalid <= 1'b1;
        @(posedge clock);
        ivalid <= 1'b0;
        // the first layer alone outlasts these cycles, so all of this lands while busy
        if (noisy) begin
            repeat (6) begin
                @(posedge clock);
                random_vector(junk_n);
                random_vector(junk_p);
                random_value(junk_d);
                draw_bits(stim_state, 1, bits);
                n <= junk_n;
                p <= junk_p;
                d <= junk_d;
                ivalid <= bits[0];
            end
            @(posedge clock);
            ivalid <= 1'b0;
        end
        do begin
            @(posedge clock);
        end while (!(ovalid && oacknowledge));
        result = inlier;
    endtask

    // acknowledge each result after 0 to 7 extra cycles
    initial begin
        logic [31:0] delay;
        oacknowledge = 1'b0;
        forever begin
            @(posedge clock);
            if (ovalid && !oacknowledge) begin
                draw_bits(ack_state, 3, delay);
                repeat (delay[2:0]) @(posedge clock);
                oacknowledge <= 1'b1;
                @(posedge clock);
                oacknowledge <= 1'b0;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("error: timed out after %0d cycles waiting for the DUT", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        vector3_s nv;
        vector3_s pv;
        single_t  dv;
        single_t  tv;
        logic     result;
        rst = 1'b1;
        ivalid = 1'b0;
        n = '0;
        p = '0;
        d = '0;
        t = '0;
        repeat (3) @(posedge clock);
        rst <= 1'b0;
        // a few idle cycles let the checker confirm the reset values
        repeat (4) @(posedge clock);

        for (int i = 0; i < random_tests; i++) begin
            random_vector(nv);
            random_vector(pv);
            random_value(dv);
            random_value(tv);
            apply_input(nv, pv, dv, tv, (i % 15) == 14, result);
        end

        // point on the plane x = 2 with n = (1, 0, 0)
        apply_input({16'h0100, 16'h0000, 16'h0000}, {16'h0200, 16'h0150, 16'hfe80},
                    16'h0200, 16'h0080, 1'b0, result);
        if (result !== 1'b1) begin
            $display("[FAIL] inlier: expected 0x1, got 0x%h for the point on the plane", result);
            tb_errors++;
        end
        // zero half-width with the point two units off the plane
        apply_input({16'h0100, 16'h0000, 16'h0000}, {16'h0300, 16'h0000, 16'h0000},
                    16'h0100, 16'h0000, 1'b0, result);
        if (result !== 1'b0) begin
            $display("[FAIL] inlier: expected 0x0, got 0x%h for zero half-width", result);
            tb_errors++;
        end
        // degenerate plane with n = 0 and d = 0 leaves a compare value of zero
        apply_input('0, {16'h0150, 16'hff00, 16'h0020}, 16'h0000, 16'h0040, 1'b0, result);
        if (result !== 1'b1) begin
            $display("[FAIL] inlier: expected 0x1, got 0x%h for n = 0 and d = 0", result);
            tb_errors++;
        end

        repeat (4) @(posedge clock);
        if (accept_count != result_count) begin
            $display("error: %0d accepted inputs but %0d results", accept_count, result_count);
            tb_errors++;
        end
        if (accept_count != random_tests + directed_tests) begin
            $display("error: %0d inputs accepted where %0d were offered", accept_count,
                     random_tests + directed_tests);
            tb_errors++;
        end
        $display("summary: %0d accepted, %0d results, %0d checker errors, %0d testbench errors",
                 accept_count, result_count, error_count, tb_errors);
        if (error_count == 0 && tb_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/inlier_pkg.sv
src/fixed_fma.sv
src/operand_capture.sv
src/first_layer_scheduler.sv
src/inlier_sequencer.sv
src/check_inlier.sv
test/inlier_checker.sv
test/tb_check_inlier.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_check_inlier -o tb_check_inlier
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_check_inlier > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
